/* sources.f */
+incdir+include
design/cache_pkg.sv
design/mem_pkg.sv
design/cache_way.sv
design/four_bank_mem.sv
design/cache_controller.sv
design/mem_system.sv
testbench/mem_system_tb.sv

/* testbench/mem_system_tb.sv */
// testbench for mem_system with clock, reset, stimulus table, LFSR random phase, model and checks
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_system_tb;

   localparam int RANDOM_COUNT = 200;
   localparam int CYCLES_PER_ACCESS = 64;

   typedef struct packed {
      logic               rd;
      logic               wr;
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] data;
      logic [`DATA_W-1:0] exp_data;
   } stim_t;

   logic               clk;
   logic               rst_n;
   logic [`ADDR_W-1:0] addr;
   logic [`DATA_W-1:0] data_in;
   logic               rd;
   logic               wr;
   logic [`DATA_W-1:0] data_out;
   logic               done;
   logic               stall;
   logic               cache_hit;
   logic               err;

   stim_t              stim_q [$];
   string              name_q [$];

   // shadow word memory and per-set tag model
   logic [`DATA_W-1:0] shadow [1 << (`ADDR_W - 1)];
   logic [`TAG_W-1:0]  m_tag [256][2];
   logic [1:0]         m_valid [256];
   logic               m_victim;

   logic [31:0]        lfsr_q;
   int                 checks;
   int                 errors;
   int                 cycles;
   int                 cycle_limit;

   mem_system mem_system_i (
      .clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: the DUT did not finish its accesses within %0d cycles", cycle_limit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // x^32 + x^22 + x^2 + x + 1 shifting right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s = s >> 1;
      if (lsb) begin
         s = s ^ 32'h8020_0003;
      end
      return s;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] value);
      value = '0;
      for (int k = 0; k < n; k++) begin
         value = {value[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task automatic add_entry(input string name, input logic r, input logic w,
                            input logic [15:0] a, input logic [15:0] d, input logic [15:0] e);
      stim_t s;
      s.rd = r;
      s.wr = w;
      s.addr = a;
      s.data = d;
      s.exp_data = e;
      stim_q.push_back(s);
      name_q.push_back(name);
   endtask

   // hit way first, then an empty way, then the victim toggle
   task automatic model_access(input logic [15:0] a, output logic hit);
      logic [`TAG_W-1:0] t;
      logic [7:0]        s;
      int                way;
      t = a[15:11];
      s = a[10:3];
      hit = 1'b1;
      if (m_valid[s][0] && m_tag[s][0] == t) begin
         way = 0;
      end else if (m_valid[s][1] && m_tag[s][1] == t) begin
         way = 1;
      end else begin
         hit = 1'b0;
         if (m_valid[s][0] && !m_valid[s][1]) begin
            way = 1;
         end else if (!m_valid[s][0] && !m_valid[s][1]) begin
            way = 0;
         end else begin
            way = m_victim;
         end
      end
      m_valid[s][way] = 1'b1;
      m_tag[s][way] = t;
      m_victim = ~m_victim;
   endtask

   // called on a falling edge and returns on the falling edge inside the done cycle
   task automatic run_access(input string name, input logic r, input logic w,
                             input logic [15:0] a, input logic [15:0] d,
                             input logic [15:0] exp_data);
      int   lat;
      logic exp_hit;
      model_access(a, exp_hit);
      rd = r;
      wr = w;
      addr = a;
      data_in = d;
      @(negedge clk);
      lat = 1;
      while (!done) begin
         check_value({name, " stall"}, 1, stall);
         @(negedge clk);
         lat++;
      end
      check_value({name, " stall at done"}, 0, stall);
      check_value({name, " cache_hit"}, exp_hit, cache_hit);
      if (r) begin
         check_value({name, " data"}, exp_data, data_out);
      end
      if (exp_hit) begin
         check_value({name, " hit latency"}, 2, lat);
      end
      if (w) begin
         shadow[a[15:1]] = d;
      end
   endtask

   task automatic run_bad_request(input string name, input logic r, input logic w,
                                  input logic [15:0] a, input logic [15:0] d);
      rd = r;
      wr = w;
      addr = a;
      data_in = d;
      repeat (4) begin
         @(negedge clk);
         check_value({name, " err"}, 1, err);
         check_value({name, " done"}, 0, done);
      end
      rd = 1'b0;
      wr = 1'b0;
      @(negedge clk);
      check_value({name, " err after withdraw"}, 0, err);
      check_value({name, " idle stall"}, 0, stall);
      check_value({name, " idle done"}, 0, done);
   endtask

   initial begin
      stim_t              s;
      logic [31:0]        bits;
      logic [`ADDR_W-1:0] a;
      logic               r;
      logic [`DATA_W-1:0] d;
      clk = 1'b0;
      rst_n = 1'b0;
      addr = '0;
      data_in = '0;
      rd = 1'b0;
      wr = 1'b0;
      checks = 0;
      errors = 0;
      cycles = 0;
      cycle_limit = 0;
      lfsr_q = 32'haa2013c6;
      m_victim = 1'b0;
      for (int i = 0; i < 256; i++) begin
         m_valid[i] = 2'b00;
      end
      for (int i = 0; i < (1 << (`ADDR_W - 1)); i++) begin
         shadow[i] = '0;
      end

      // set 5 holds tags 1, 2 and 3 and set 9 holds tag 4
      add_entry("cold_load", 1, 0, 16'h0828, 16'h0000, 16'h0000);
      add_entry("reload", 1, 0, 16'h0828, 16'h0000, 16'h0000);
      add_entry("store_miss", 0, 1, 16'h204a, 16'hbeef, 16'h0000);
      add_entry("load_stored", 1, 0, 16'h204a, 16'h0000, 16'hbeef);
      add_entry("load_neighbor", 1, 0, 16'h204c, 16'h0000, 16'h0000);
      add_entry("dirty_tag1", 0, 1, 16'h0828, 16'h1111, 16'h0000);
      add_entry("dirty_tag2", 0, 1, 16'h102e, 16'h2222, 16'h0000);
      add_entry("evict_by_tag3", 1, 0, 16'h1828, 16'h0000, 16'h0000);
      add_entry("tag2_from_mem", 1, 0, 16'h102e, 16'h0000, 16'h2222);
      add_entry("tag1_from_mem", 1, 0, 16'h0828, 16'h0000, 16'h1111);
      add_entry("tag2_hit", 1, 0, 16'h102e, 16'h0000, 16'h2222);
      add_entry("rd_and_wr", 1, 1, 16'h0828, 16'h5555, 16'h0000);
      add_entry("odd_load", 1, 0, 16'h0829, 16'h0000, 16'h0000);
      add_entry("odd_store", 0, 1, 16'h0831, 16'h7777, 16'h0000);
      add_entry("after_err", 1, 0, 16'h0828, 16'h0000, 16'h1111);
      cycle_limit = CYCLES_PER_ACCESS * (stim_q.size() + RANDOM_COUNT);

      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("reset done", 0, done);
      check_value("reset stall", 0, stall);
      check_value("reset cache_hit", 0, cache_hit);
      check_value("reset err", 0, err);

      foreach (stim_q[i]) begin
         s = stim_q[i];
         if ((s.rd && s.wr) || s.addr[0]) begin
            run_bad_request(name_q[i], s.rd, s.wr, s.addr, s.data);
         end else begin
            run_access(name_q[i], s.rd, s.wr, s.addr, s.data, s.exp_data);
         end
      end

      // random phase over sets 0 to 3 with eight tags each
      for (int n = 0; n < RANDOM_COUNT; n++) begin
         take_bits(1, bits);
         r = bits[0];
         take_bits(7, bits);
         a = {2'b00, bits[6:4], 6'd0, bits[3:2], bits[1:0], 1'b0};
         take_bits(16, bits);
         d = bits[15:0];
         run_access($sformatf("rand_%0d", n), r, ~r, a, d, shadow[a[15:1]]);
      end

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* design/mem_system.sv */
// top of the two-way cache with its controller and the banked main memory
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_system (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [`ADDR_W-1:0] addr,
   input  logic [`DATA_W-1:0] data_in,
   input  logic               rd,
   input  logic               wr,
   output logic [`DATA_W-1:0] data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err
);
   import cache_pkg::*;
   import mem_pkg::*;

   cache_addr_t        line_addr;
   way_status_t        status0;
   way_status_t        status1;
   logic [`DATA_W-1:0] rdata0;
   logic [`DATA_W-1:0] rdata1;
   logic [`DATA_W-1:0] cache_wdata;
   logic               enable;
   logic               comp;
   logic               write0;
   logic               write1;
   mem_req_t           mem_req;
   mem_rsp_t           mem_rsp;
   logic               mem_err;

   cache_way way0 (
      .clk(clk), .rst_n(rst_n), .enable(enable), .comp(comp), .write(write0),
      .line_addr(line_addr), .wdata(cache_wdata), .status(status0), .rdata(rdata0)
   );

   cache_way way1 (
      .clk(clk), .rst_n(rst_n), .enable(enable), .comp(comp), .write(write1),
      .line_addr(line_addr), .wdata(cache_wdata), .status(status1), .rdata(rdata1)
   );

   cache_controller ctrl (
      .clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .status0(status0), .status1(status1), .rdata0(rdata0), .rdata1(rdata1),
      .line_addr(line_addr), .cache_wdata(cache_wdata), .enable(enable), .comp(comp),
      .write0(write0), .write1(write1), .mem_req(mem_req), .mem_rsp(mem_rsp),
      .mem_err(mem_err), .data_out(data_out), .done(done), .stall(stall),
      .cache_hit(cache_hit), .err(err)
   );

   four_bank_mem mem (
      .clk(clk), .rst_n(rst_n), .req(mem_req), .rsp(mem_rsp), .err(mem_err)
   );

endmodule

/* design/cache_controller.sv */
// access FSM with way choice, victim bit, write-back and fill sequencing for the two-way cache
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_controller (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`ADDR_W-1:0]     addr,
   input  logic [`DATA_W-1:0]     data_in,
   input  logic                   rd,
   input  logic                   wr,
   input  cache_pkg::way_status_t status0,
   input  cache_pkg::way_status_t status1,
   input  logic [`DATA_W-1:0]     rdata0,
   input  logic [`DATA_W-1:0]     rdata1,
   output cache_pkg::cache_addr_t line_addr,
   output logic [`DATA_W-1:0]     cache_wdata,
   output logic                   enable,
   output logic                   comp,
   output logic                   write0,
   output logic                   write1,
   output mem_pkg::mem_req_t      mem_req,
   input  mem_pkg::mem_rsp_t      mem_rsp,
   input  logic                   mem_err,
   output logic [`DATA_W-1:0]     data_out,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err
);
   import cache_pkg::*;

   localparam int WORD_W = $clog2(`LINE_WORDS);

   ctrl_state_t        state_q;
   ctrl_state_t        state_d;
   ctrl_state_t        next_req;
   logic [WORD_W-1:0]  word_q;
   logic [WORD_W-1:0]  word_d;
   logic               sel_q;
   logic               sel_d;
   logic               hit_q;
   logic               hit_d;
   logic               victim_q;

   cache_addr_t        cpu_addr;
   logic [`OFFSET_W-1:0] line_off;
   logic               bad_req;
   logic               any_hit;
   logic               choose;
   logic               tgt;
   logic               write;
   way_status_t        tgt_status;
   logic [`DATA_W-1:0] tgt_rdata;

   assign cpu_addr = addr;
   assign line_off = {word_q, 1'b0};
   assign bad_req  = (rd & wr) | ((rd | wr) & addr[0]);
   assign next_req = bad_req ? ST_ERR : ((rd | wr) ? ST_COMP : ST_IDLE);

   assign any_hit = status0.hit | status1.hit;

   // hit first, then an empty way, then the global victim bit
   always_comb begin
      if (status0.hit) begin
         choose = 1'b0;
      end else if (status1.hit) begin
         choose = 1'b1;
      end else if (status0.valid && !status1.valid) begin
         choose = 1'b1;
      end else if (!status0.valid && !status1.valid) begin
         choose = 1'b0;
      end else begin
         choose = victim_q;
      end
   end

   // choice is live in compare and latched for the rest of the access
   assign tgt        = (state_q == ST_COMP) ? choose : sel_q;
   assign tgt_status = tgt ? status1 : status0;
   assign tgt_rdata  = tgt ? rdata1 : rdata0;

   assign write0 = write & ~tgt;
   assign write1 = write & tgt;

   assign data_out  = sel_q ? rdata1 : rdata0;
   assign cache_hit = (state_q == ST_DONE) & hit_q;
   assign err       = (state_q == ST_ERR) | mem_err;

   always_comb begin
      state_d     = state_q;
      word_d      = word_q;
      sel_d       = sel_q;
      hit_d       = hit_q;
      line_addr   = cpu_addr;
      cache_wdata = data_in;
      enable      = 1'b0;
      comp        = 1'b0;
      write       = 1'b0;
      mem_req     = '0;
      done        = 1'b0;
      stall       = 1'b1;
      unique case (state_q)
         ST_IDLE: begin
            stall   = 1'b0;
            state_d = next_req;
         end
         ST_COMP: begin
            enable = 1'b1;
            comp   = 1'b1;
            sel_d  = choose;
            hit_d  = any_hit;
            word_d = '0;
            if (any_hit) begin
               write   = wr;
               state_d = ST_DONE;
            end else if (tgt_status.valid && tgt_status.dirty) begin
               state_d = ST_WB;
            end else begin
               state_d = ST_MEMRD;
            end
         end
         ST_WB: begin
            // victim tag still sits in the way until the fill
            enable           = 1'b1;
            line_addr.offset = line_off;
            mem_req.wr       = 1'b1;
            mem_req.addr     = {tgt_status.tag, cpu_addr.index, line_off};
            mem_req.wdata    = tgt_rdata;
            if (!mem_rsp.stall) begin
               word_d = word_q + WORD_W'(1);
               if (word_q == WORD_W'(`LINE_WORDS - 1)) begin
                  state_d = ST_MEMRD;
               end
            end
         end
         ST_MEMRD: begin
            line_addr.offset = line_off;
            mem_req.rd       = 1'b1;
            mem_req.addr     = {cpu_addr.tag, cpu_addr.index, line_off};
            if (!mem_rsp.stall) begin
               state_d = ST_WAIT;
            end
         end
         ST_WAIT: begin
            line_addr.offset = line_off;
            state_d          = ST_FILL;
         end
         ST_FILL: begin
            enable           = 1'b1;
            write            = 1'b1;
            line_addr.offset = line_off;
            cache_wdata      = mem_rsp.rdata;
            word_d           = word_q + WORD_W'(1);
            if (word_q == WORD_W'(`LINE_WORDS - 1)) begin
               state_d = wr ? ST_STORE : ST_DONE;
            end else begin
               state_d = ST_MEMRD;
            end
         end
         ST_STORE: begin
            // line is present now, so the compare write hits
            enable  = 1'b1;
            comp    = 1'b1;
            write   = 1'b1;
            state_d = ST_DONE;
         end
         ST_DONE: begin
            enable  = 1'b1;
            done    = 1'b1;
            stall   = 1'b0;
            state_d = next_req;
         end
         ST_ERR: begin
            state_d = bad_req ? ST_ERR : ST_IDLE;
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q  <= ST_IDLE;
         word_q   <= '0;
         sel_q    <= 1'b0;
         hit_q    <= 1'b0;
         victim_q <= 1'b0;
      end else begin
         state_q <= state_d;
         word_q  <= word_d;
         sel_q   <= sel_d;
         hit_q   <= hit_d;
         if (state_q == ST_DONE) begin
            victim_q <= ~victim_q;
         end
      end
   end

   // a stalled memory request waits unchanged for its bank
   a_stalled_req_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      (mem_req.rd || mem_req.wr) && mem_rsp.stall |=> $stable(mem_req)
   );

   // the fill leaves the line valid under the new tag
   a_store_after_fill_hits: assert property (
      @(posedge clk) disable iff (!rst_n)
      state_q == ST_STORE |-> any_hit
   );

endmodule

/* design/four_bank_mem.sv */
// word-interleaved four-bank main memory with bank busy timers, stall and read pipeline
`timescale 1ns/1ps
`include "mem_config.svh"

module four_bank_mem (
   input  logic              clk,
   input  logic              rst_n,
   input  mem_pkg::mem_req_t req,
   output mem_pkg::mem_rsp_t rsp,
   output logic              err
);

   localparam int WORDS  = 1 << (`ADDR_W - 1);
   localparam int BANK_W = $clog2(`NUM_BANKS);
   localparam int CNT_W  = $clog2(`BANK_BUSY + 1);

   logic [`DATA_W-1:0] mem [WORDS];
   logic [CNT_W-1:0]   busy_q [`NUM_BANKS];

   logic [`ADDR_W-2:0] word_idx;
   logic [BANK_W-1:0]  bank;
   logic               stall;
   logic               accept;
   logic [`DATA_W-1:0] rdata_s1;
   logic [`DATA_W-1:0] rdata_s2;

   // memory powers up cleared
   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = '0;
      end
   end

   assign word_idx = req.addr[`ADDR_W-1:1];
   // consecutive words land in consecutive banks
   assign bank     = req.addr[BANK_W:1];

   assign stall  = (req.rd | req.wr) & (busy_q[bank] != '0);
   assign accept = (req.rd ^ req.wr) & ~stall;
   assign err    = req.rd & req.wr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            busy_q[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `NUM_BANKS; b++) begin
            if (accept && bank == BANK_W'(b)) begin
               busy_q[b] <= CNT_W'(`BANK_BUSY);
            end else if (busy_q[b] != '0) begin
               busy_q[b] <= busy_q[b] - 1'b1;
            end
         end
      end
   end

   // array access and then one more stage before the data reaches the port
   always_ff @(posedge clk) begin
      if (accept && req.wr) begin
         mem[word_idx] <= req.wdata;
      end
      if (accept && req.rd) begin
         rdata_s1 <= mem[word_idx];
      end
      rdata_s2 <= rdata_s1;
   end

   assign rsp.rdata = rdata_s2;
   assign rsp.stall = stall;

   // a bank that took a request rests for the whole busy time
   for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank_rest
      a_bank_rest: assert property (
         @(posedge clk) disable iff (!rst_n)
         (accept && bank == BANK_W'(b)) |=>
            (!(accept && bank == BANK_W'(b))) [*`BANK_BUSY]
      );
   end

endmodule

/* design/cache_way.sv */
// one cache way with tag, valid, dirty and data arrays, lookup and write
`timescale 1ns/1ps
`include "mem_config.svh"

module cache_way (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,
   input  logic                   comp,
   input  logic                   write,
   input  cache_pkg::cache_addr_t line_addr,
   input  logic [`DATA_W-1:0]     wdata,
   output cache_pkg::way_status_t status,
   output logic [`DATA_W-1:0]     rdata
);

   localparam int SETS   = 1 << `INDEX_W;
   localparam int WORD_W = $clog2(`LINE_WORDS);

   logic [`TAG_W-1:0]          tag_arr [SETS];
   logic [SETS-1:0]            valid_arr;
   logic [SETS-1:0]            dirty_arr;
   logic [`DATA_W-1:0]         data_arr [SETS*`LINE_WORDS];

   logic [`INDEX_W-1:0]        idx;
   logic [`INDEX_W+WORD_W-1:0] word_idx;
   logic                       tag_match;
   logic                       hit;
   logic                       wr_plain;
   logic                       wr_comp;

   assign idx      = line_addr.index;
   // byte offset bit 0 is always zero for word accesses
   assign word_idx = {idx, line_addr.offset[`OFFSET_W-1:1]};

   assign tag_match = (tag_arr[idx] == line_addr.tag);
   assign hit       = enable & comp & valid_arr[idx] & tag_match;

   // fill writes whatever it is given and compare mode only on a hit
   assign wr_plain = enable & write & ~comp;
   assign wr_comp  = hit & write;

   always_comb begin
      status.hit   = hit;
      status.valid = valid_arr[idx];
      status.dirty = dirty_arr[idx];
      status.tag   = tag_arr[idx];
   end

   assign rdata = data_arr[word_idx];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_arr <= '0;
         dirty_arr <= '0;
      end else if (wr_plain) begin
         valid_arr[idx] <= 1'b1;
         dirty_arr[idx] <= 1'b0;
      end else if (wr_comp) begin
         dirty_arr[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_plain) begin
         tag_arr[idx] <= line_addr.tag;
      end
      if (wr_plain || wr_comp) begin
         data_arr[word_idx] <= wdata;
      end
   end

   // the controller only strobes a way it has enabled
   a_write_needs_enable: assert property (
      @(posedge clk) disable iff (!rst_n)
      write |-> enable
   );

endmodule

/* design/mem_pkg.sv */
// backing memory request and response types
`include "mem_config.svh"

package mem_pkg;

   // one access to the banked memory at an even byte address
   typedef struct packed {
      logic               rd;
      logic               wr;
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] wdata;
   } mem_req_t;

   // rdata is valid two cycles after a read is taken
   typedef struct packed {
      logic [`DATA_W-1:0] rdata;
      logic               stall;
   } mem_rsp_t;

endpackage

/* design/cache_pkg.sv */
// cache types for the split address, way lookup status and controller states
`include "mem_config.svh"

package cache_pkg;

   // byte address as the cache sees it
   typedef struct packed {
      logic [`TAG_W-1:0]    tag;
      logic [`INDEX_W-1:0]  index;
      logic [`OFFSET_W-1:0] offset;
   } cache_addr_t;

   // what one way reports for the addressed set
   typedef struct packed {
      logic              hit;
      logic              valid;
      logic              dirty;
      logic [`TAG_W-1:0] tag;
   } way_status_t;

   typedef enum logic [4:0] {
      ST_IDLE  = 5'h00,
      ST_COMP  = 5'h01,
      ST_WB    = 5'h02,
      ST_MEMRD = 5'h03,
      ST_WAIT  = 5'h04,
      ST_FILL  = 5'h05,
      ST_STORE = 5'h06,
      ST_DONE  = 5'h07,
      ST_ERR   = 5'h10
   } ctrl_state_t;

endpackage

/* include/mem_config.svh */
// address, data, set, line and bank geometry plus the bank busy time
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// cpu side
`define ADDR_W      16
`define DATA_W      16

// address split is tag, index, offset
`define TAG_W       5
`define INDEX_W     8
`define OFFSET_W    3
`define LINE_WORDS  4

// backing memory
`define NUM_BANKS   4
// cycles a bank stays busy after it takes a request
`define BANK_BUSY   4

`endif
